// ==== Bender.yml ====
package:
  name: wrra_qos

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wrra_pkg.sv
      - verilog/weight_counter.sv
      - verilog/rr_priority_arbiter.sv
      - verilog/wrra_arbiter.sv
      - verilog/contention_gen.sv
      - verilog/header_weight_stamp.sv
      - verilog/wrra_qos.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/wrra_qos_props.sv
      - test/wrra_qos_tb.sv

// ==== test/wrra_qos_props.sv ====
/*
 * concurrent checks on the allocator grants
 * bound into wrra_qos by the testbench, failures counted in fail_count
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module wrra_qos_props (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire wrra_pkg::port_mask_t                  req_i,
    input  wire wrra_pkg::port_mask_t [`WRRA_PORTS-1:0] dest_i,
    input  wire wrra_pkg::port_mask_t [`WRRA_PORTS-1:0] grant_i,   // [output][input]
    input  wire wrra_pkg::port_mask_t                  valid_i
);
    import wrra_pkg::*;

    port_mask_t [`WRRA_PORTS-1:0] wants;   // [output][input]
    int fail_count = 0;

    always_comb begin
        for (int j = 0; j < `WRRA_PORTS; j++) begin
            for (int i = 0; i < `WRRA_PORTS; i++) begin
                wants[j][i] = req_i[i] & dest_i[i][j];
            end
        end
    end

    for (genvar j = 0; j < `WRRA_PORTS; j++) begin : g_out
        a_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(grant_i[j]))
            else begin
                $error("output %0d granted more than one input", j);
                fail_count++;
            end

        a_to_requester: assert property (@(posedge clk) disable iff (reset)
            (grant_i[j] & ~wants[j]) == '0)
            else begin
                $error("output %0d granted an input that did not request it", j);
                fail_count++;
            end

        a_valid: assert property (@(posedge clk) disable iff (reset)
            valid_i[j] == (|grant_i[j]))
            else begin
                $error("output %0d valid does not match its grant", j);
                fail_count++;
            end

        // quiet inputs during reset give no grant
        a_reset_quiet: assert property (@(posedge clk)
            (reset && req_i == '0) |-> (grant_i[j] == '0 && !valid_i[j]))
            else begin
                $error("output %0d granted during reset", j);
                fail_count++;
            end
    end

endmodule

`default_nettype wire

// ==== test/wrra_qos_tb.sv ====
/*
 * testbench for the weighted round-robin switch allocator
 * directed tests then random traffic with every cycle compared against a reference model
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module wrra_qos_tb;
    import wrra_pkg::*;

    localparam int N           = `WRRA_PORTS;
    localparam int W_MAX       = (1 << `WRRA_WEIGHT_W) - 1;
    localparam int PERIOD      = 20;
    localparam int RAND_CYCLES = 2000;
    localparam int DIR_CYCLES  = 150;   // directed tests and resets rounded up

    // expected outputs of one cycle
    typedef struct packed {
        port_mask_t [N-1:0] grant;
        port_mask_t         valid;
        flit_vec_t          flit;
        weight_vec_t        cont;
    } expect_t;

    logic               clk;
    logic               reset;
    port_mask_t         req;
    port_mask_t [N-1:0] dest;
    weight_vec_t        weight;
    flit_vec_t          flit_in;
    port_mask_t [N-1:0] grant;
    port_mask_t         valid;
    flit_vec_t          flit_out;
    weight_vec_t        cont;

    weight_t     m_cnt [N][N];   // model counters [output][input]
    int          m_ptr [N];
    logic [31:0] lcg_state;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          seq [$];        // winners seen on one output

    wrra_qos dut (
        .clk            (clk),
        .reset          (reset),
        .req_i          (req),
        .dest_i         (dest),
        .iport_weight_i (weight),
        .flit_i         (flit_in),
        .grant_o        (grant),
        .out_valid_o    (valid),
        .flit_o         (flit_out),
        .contention_o   (cont)
    );

    bind wrra_qos wrra_qos_props u_props (
        .clk     (clk),
        .reset   (reset),
        .req_i   (req_i),
        .dest_i  (dest_i),
        .grant_i (grant_o),
        .valid_i (out_valid_o)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // contention, winner and stamped flit per output from the model state
    function automatic expect_t ref_model(port_mask_t r, port_mask_t [N-1:0] d,
                                          weight_vec_t w, flit_vec_t f);
        expect_t e;
        int      sum;
        int      idx;
        bit      found;
        flit_t   fl;
        e = '0;
        for (int j = 0; j < N; j++) begin
            sum = 0;
            for (int i = 0; i < N; i++) begin
                if (r[i] && d[i][j]) begin
                    sum += int'(w[i]);
                end
            end
            e.cont[j] = weight_t'((sum > W_MAX) ? W_MAX : sum);
            found = 1'b0;
            for (int k = 0; k < N; k++) begin
                idx = (m_ptr[j] + k) % N;   // upward from the pointer with wrap
                if (!found && r[idx] && d[idx][j]) begin
                    found           = 1'b1;
                    e.grant[j][idx] = 1'b1;
                    e.valid[j]      = 1'b1;
                    fl              = f[idx];
                    if (fl.is_hdr) begin
                        fl.weight = e.cont[j];
                    end
                    e.flit[j] = fl;
                end
            end
        end
        return e;
    endfunction

    // state as taken at the coming rising edge
    task automatic step_model(weight_vec_t w, expect_t e);
        weight_t eff;
        weight_t nxt;
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                eff = (w[i] == '0) ? weight_t'(1) : w[i];
                nxt = m_cnt[j][i];
                if (m_cnt[j][i] > w[i]) begin
                    nxt = eff - weight_t'(1);
                end
                if (e.grant[j][i]) begin
                    if (m_cnt[j][i] == '0) begin
                        nxt      = eff - weight_t'(1);   // weight consumed
                        m_ptr[j] = (i + 1) % N;
                    end else begin
                        nxt = m_cnt[j][i] - weight_t'(1);
                    end
                end
                m_cnt[j][i] = nxt;
            end
        end
    endtask

    task automatic clear_model();
        for (int j = 0; j < N; j++) begin
            m_ptr[j] = 0;
            for (int i = 0; i < N; i++) begin
                m_cnt[j][i] = '0;
            end
        end
    endtask

    task automatic flag_mismatch(string what, logic [127:0] exp_v, logic [127:0] act_v);
        $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        test_errs++;
    endtask

    // inputs are settled at the falling edge
    always @(negedge clk) begin : compare
        expect_t e;
        if (reset) begin
            clear_model();
        end
        e = ref_model(req, dest, weight, flit_in);
        assert (grant === e.grant) else flag_mismatch("grant", e.grant, grant);
        assert (valid === e.valid) else flag_mismatch("out_valid", e.valid, valid);
        assert (cont === e.cont) else flag_mismatch("contention", e.cont, cont);
        assert (flit_out === e.flit) else flag_mismatch("flit", e.flit, flit_out);
        if (!reset) begin
            step_model(weight, e);
        end
    end

    task automatic drive_idle();
        req     <= '0;
        dest    <= '0;
        weight  <= '0;
        flit_in <= '0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        drive_idle();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    // one idle cycle so the last compare lands in this test
    task automatic end_test();
        @(posedge clk);
        drive_idle();
        @(posedge clk);
        $display("test %-16s %s, %0d errors", test_name,
                 (test_errs == 0) ? "ok" : "failed", test_errs);
        total_errs += test_errs;
        tests_run++;
    endtask

    task automatic collect_winners(int out, int cycles);
        int w_idx;
        seq.delete();
        repeat (cycles) begin
            @(negedge clk);
            w_idx = -1;   // no winner
            for (int i = 0; i < N; i++) begin
                if (grant[out][i]) begin
                    w_idx = i;
                end
            end
            seq.push_back(w_idx);
        end
    endtask

    task automatic reset_state_test();
        start_test("reset_state");
        @(posedge clk);
        reset <= 1'b1;
        drive_idle();
        @(negedge clk);
        assert (valid === '0 && grant === '0) else flag_mismatch("grant in reset", 0, grant);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (valid === '0 && grant === '0) else flag_mismatch("grant after reset", 0, grant);
        assert (cont === '0) else flag_mismatch("contention after reset", 0, cont);
        end_test();
    endtask

    task automatic weighted_share_test();
        int exp_win;
        start_test("weighted_share");
        apply_reset();
        req       <= 5'b00011;
        dest[0]   <= 5'b00001;   // both want output 0
        dest[1]   <= 5'b00001;
        weight[0] <= weight_t'(3);
        weight[1] <= weight_t'(1);
        collect_winners(0, 18);
        for (int k = 0; k < seq.size(); k++) begin
            // first grants consume at once and then three to input 0 and one to input 1
            exp_win = (k < 2) ? k : (((k - 2) % 4 == 3) ? 1 : 0);
            assert (seq[k] == exp_win)
                else flag_mismatch($sformatf("winner %0d", k), exp_win, seq[k]);
        end
        end_test();
    endtask

    task automatic zero_weight_test();
        int exp_win;
        start_test("zero_weight");
        apply_reset();
        req     <= 5'b10100;
        dest[2] <= 5'b00010;   // output 1
        dest[4] <= 5'b00010;
        collect_winners(1, 10);
        for (int k = 0; k < seq.size(); k++) begin
            exp_win = (k % 2 == 0) ? 2 : 4;   // weight 0 acts as 1
            assert (seq[k] == exp_win)
                else flag_mismatch($sformatf("winner %0d", k), exp_win, seq[k]);
        end
        end_test();
    endtask

    task automatic contention_sum_test();
        weight_vec_t exp_c;
        start_test("contention");
        apply_reset();
        req    <= 5'b01111;
        dest   <= {5'b00001, 5'b00100, 5'b00100, 5'b00100, 5'b00100};
        weight <= {4'd7, 4'd15, 4'd15, 4'd15, 4'd15};
        @(negedge clk);
        exp_c = {4'd0, 4'd0, 4'd15, 4'd0, 4'd0};   // four full weights saturate
        assert (cont === exp_c) else flag_mismatch("saturated sum", exp_c, cont);
        @(posedge clk);
        dest   <= {5'b00001, 5'b01000, 5'b01000, 5'b00001, 5'b00001};
        weight <= {4'd7, 4'd5, 4'd4, 4'd3, 4'd2};
        @(negedge clk);
        exp_c = {4'd0, 4'd9, 4'd0, 4'd0, 4'd5};    // input 4 not requesting
        assert (cont === exp_c) else flag_mismatch("plain sums", exp_c, cont);
        end_test();
    endtask

    task automatic header_stamp_test();
        flit_t hdr;
        flit_t body;
        flit_t exp_hdr;
        start_test("header_stamp");
        apply_reset();
        hdr  = '{is_hdr: 1'b1, is_tail: 1'b0, weight: 4'd2, dst: 3'd1, data: 16'hbeef};
        body = '{is_hdr: 1'b0, is_tail: 1'b1, weight: 4'd3, dst: 3'd2, data: 16'h1234};
        exp_hdr        = hdr;
        exp_hdr.weight = 4'd6;   // contention of output 1
        req        <= 5'b00011;
        dest[0]    <= 5'b00010;
        dest[1]    <= 5'b00100;
        weight[0]  <= weight_t'(6);
        weight[1]  <= weight_t'(9);
        flit_in[0] <= hdr;
        flit_in[1] <= body;
        @(negedge clk);
        assert (flit_out[1] === exp_hdr) else flag_mismatch("header flit", exp_hdr, flit_out[1]);
        assert (flit_out[2] === body) else flag_mismatch("body flit", body, flit_out[2]);
        assert (flit_out[0] === '0 && flit_out[3] === '0 && flit_out[4] === '0)
            else flag_mismatch("idle outputs", 0, {flit_out[4], flit_out[3], flit_out[0]});
        end_test();
    endtask

    task automatic random_traffic_test();
        logic [31:0] r;
        start_test("random_traffic");
        apply_reset();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            r = next_rand();
            req <= r[31:27];
            if (c % 16 == 0) begin   // weights hold for a while
                for (int i = 0; i < N; i++) begin
                    r = next_rand();
                    weight[i] <= r[31:28];
                end
            end
            for (int i = 0; i < N; i++) begin
                r = next_rand();
                dest[i] <= port_mask_t'(1) << (r[31:24] % N);
                r = next_rand();
                flit_in[i] <= r[31:7];
            end
            @(posedge clk);
        end
        end_test();
    endtask

    initial begin
        reset      = 1'b1;
        req        = '0;
        dest       = '0;
        weight     = '0;
        flit_in    = '0;
        lcg_state  = 32'h0062_1a1d;
        test_errs  = 0;
        total_errs = 0;
        tests_run  = 0;
        test_name  = "startup";
        clear_model();

        reset_state_test();
        weighted_share_test();
        zero_weight_test();
        contention_sum_test();
        header_stamp_test();
        random_traffic_test();

        total_errs += dut.u_props.fail_count;
        $display("%0d tests run, %0d errors, %0d property failures",
                 tests_run, total_errs, dut.u_props.fail_count);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // directed and random cycles plus a margin
    initial begin
        #((RAND_CYCLES + DIR_CYCLES) * PERIOD + 1000);
        $display("watchdog timeout, tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/contention_gen.sv ====
/*
 * contention per output port
 * saturating sum of the weights of all inputs requesting that output
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module contention_gen (
    input  wire wrra_pkg::port_mask_t                  req_i,
    input  wire wrra_pkg::port_mask_t [`WRRA_PORTS-1:0] dest_i,
    input  wire wrra_pkg::weight_vec_t                 iport_weight_i,
    output wrra_pkg::weight_vec_t                      contention_o
);
    import wrra_pkg::*;

    localparam int N     = `WRRA_PORTS;
    localparam int W     = `WRRA_WEIGHT_W;
    localparam int SUM_W = W + $clog2(N);   // room for N full weights

    port_mask_t [N-1:0] req_dest;   // per input, destination if requesting
    port_mask_t [N-1:0] out_sel;    // per output, which inputs want it

    always_comb begin
        for (int i = 0; i < N; i++) begin
            req_dest[i] = req_i[i] ? dest_i[i] : '0;
        end
    end

    // transpose to the output view
    always_comb begin
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                out_sel[j][i] = req_dest[i][j];
            end
        end
    end

    always_comb begin
        logic [SUM_W-1:0] sum;
        for (int j = 0; j < N; j++) begin
            sum = '0;
            for (int i = 0; i < N; i++) begin
                if (out_sel[j][i]) begin
                    sum = sum + SUM_W'(iport_weight_i[i]);
                end
            end
            // clamp to max weight
            if (sum[SUM_W-1:W] != '0) begin
                contention_o[j] = '1;
            end else begin
                contention_o[j] = sum[W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/header_weight_stamp.sv ====
/*
 * crossbar column for one output port
 * passes the granted flit, header flits carry this output's contention
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module header_weight_stamp (
    input  wire wrra_pkg::port_mask_t  grant_i,
    input  wire wrra_pkg::flit_vec_t   flit_i,
    input  wire wrra_pkg::weight_t     contention_i,
    output wrra_pkg::flit_t            flit_o
);
    import wrra_pkg::*;

    flit_t sel_flit;

    // and-or mux, grant is one-hot or zero
    always_comb begin
        sel_flit = '0;
        for (int i = 0; i < `WRRA_PORTS; i++) begin
            if (grant_i[i]) begin
                sel_flit = sel_flit | flit_i[i];
            end
        end
    end

    always_comb begin
        flit_o = sel_flit;   // all zeros when nobody won
        if (sel_flit.is_hdr) begin
            flit_o.weight = contention_i;  // downstream sees congestion met here
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rr_priority_arbiter.sv ====
/*
 * round-robin arbiter with a registered priority pointer
 * the pointer moves past the winner only when priority_en_i is high
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module rr_priority_arbiter (
    input  wire                        clk,
    input  wire                        reset,
    input  wire wrra_pkg::port_mask_t  request_i,
    input  wire                        priority_en_i,
    output wrra_pkg::port_mask_t       grant_o,
    output logic                       any_grant_o
);
    import wrra_pkg::*;

    localparam int N     = `WRRA_PORTS;
    localparam int IDX_W = $clog2(N);

    logic [IDX_W-1:0] ptr_q;     // highest priority input
    logic [IDX_W-1:0] win_idx;
    logic [IDX_W-1:0] next_ptr;
    port_mask_t       grant;

    // far offsets first so the nearest requester overrides
    always_comb begin
        int cand;
        grant   = '0;
        win_idx = ptr_q;
        for (int k = N - 1; k >= 0; k--) begin
            cand = int'(ptr_q) + k;
            if (cand >= N) begin
                cand = cand - N;   // wrap
            end
            if (request_i[cand]) begin
                grant       = '0;
                grant[cand] = 1'b1;
                win_idx     = IDX_W'(cand);
            end
        end
    end

    assign next_ptr    = (win_idx == IDX_W'(N - 1)) ? '0 : win_idx + 1'b1;
    assign grant_o     = grant;
    assign any_grant_o = |grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (any_grant_o && priority_en_i) begin
            ptr_q <= next_ptr;   // one past the winner
        end
    end

endmodule

`default_nettype wire

// ==== verilog/weight_counter.sv ====
/*
 * remaining-weight counter for one input of a weighted arbiter
 * consumed_o high means the next grant uses up this input's weight
 */
`timescale 1ns/100ps
`default_nettype none

module weight_counter (
    input  wire                    clk,
    input  wire                    reset,
    input  wire wrra_pkg::weight_t weight_i,
    input  wire                    decr_i,      // own grant bit
    output logic                   consumed_o
);
    import wrra_pkg::*;

    weight_t count_q;
    weight_t count_d;
    weight_t eff_weight;
    logic    count_zero;

    assign eff_weight = (weight_i == '0) ? weight_t'(1) : weight_i;  // zero acts as one
    assign count_zero = (count_q == '0);
    assign consumed_o = count_zero;

    always_comb begin
        count_d = count_q;
        // weight lowered below what is left
        if (count_q > weight_i) begin
            count_d = eff_weight - weight_t'(1);
        end
        if (decr_i) begin
            if (count_zero) begin
                count_d = eff_weight - weight_t'(1);  // consumed, start a new share
            end else begin
                count_d = count_q - weight_t'(1);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wrra_arbiter.sv ====
/*
 * weighted round-robin arbiter for one output port
 * priority stays on the winner until its weight is consumed
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module wrra_arbiter (
    input  wire                          clk,
    input  wire                          reset,
    input  wire wrra_pkg::port_mask_t    request_i,
    input  wire wrra_pkg::weight_vec_t   weight_i,
    output wrra_pkg::port_mask_t         grant_o,
    output logic                         any_grant_o
);
    import wrra_pkg::*;

    port_mask_t consumed;          // per input, counter at zero
    logic       winner_consumed;

    // one counter per input, stepped by its own grant
    for (genvar i = 0; i < `WRRA_PORTS; i++) begin : g_cnt
        weight_counter u_cnt (
            .clk        (clk),
            .reset      (reset),
            .weight_i   (weight_i[i]),
            .decr_i     (grant_o[i]),
            .consumed_o (consumed[i])
        );
    end

    // one-hot select of the winner's flag
    assign winner_consumed = |(grant_o & consumed);

    rr_priority_arbiter u_rr (
        .clk           (clk),
        .reset         (reset),
        .request_i     (request_i),
        .priority_en_i (winner_consumed),  // lock until weight used up
        .grant_o       (grant_o),
        .any_grant_o   (any_grant_o)
    );

endmodule

`default_nettype wire

// ==== verilog/wrra_defs.svh ====
/*
 * sizes shared by the weighted round-robin switch allocator
 * include before any file that sizes ports, weights or flit fields
 */
`ifndef WRRA_DEFS_SVH
`define WRRA_DEFS_SVH

// router ports, local port included
`define WRRA_PORTS 5

// weight and contention width, max weight is 2**W-1
`define WRRA_WEIGHT_W 4

// destination field of a header flit
`define WRRA_DST_W 3

// remaining payload bits of a flit
`define WRRA_DATA_W 16

`endif

// ==== verilog/wrra_pkg.sv ====
/*
 * shared types of the weighted round-robin switch allocator
 * modules import it with wrra_pkg::* inside their body
 */
`default_nettype none

`include "wrra_defs.svh"

package wrra_pkg;

    // one weight, or one contention value
    typedef logic [`WRRA_WEIGHT_W-1:0] weight_t;

    typedef logic [`WRRA_PORTS-1:0] port_mask_t;     // requests, destinations, grants

    typedef weight_t [`WRRA_PORTS-1:0] weight_vec_t; // one weight per port

    // flit as it moves through the crossbar
    typedef struct packed {
        logic                    is_hdr;
        logic                    is_tail;
        weight_t                 weight;   // rewritten with contention on headers
        logic [`WRRA_DST_W-1:0]  dst;
        logic [`WRRA_DATA_W-1:0] data;
    } flit_t;

    typedef flit_t [`WRRA_PORTS-1:0] flit_vec_t;     // one flit per port

endpackage

`default_nettype wire

// ==== verilog/wrra_qos.sv ====
/*
 * weighted round-robin switch allocator with QoS header stamping
 * one arbiter and one crossbar column per output, all grants same cycle
 */
`timescale 1ns/100ps
`default_nettype none

`include "wrra_defs.svh"

module wrra_qos (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire wrra_pkg::port_mask_t                  req_i,
    input  wire wrra_pkg::port_mask_t [`WRRA_PORTS-1:0] dest_i,          // one-hot per input
    input  wire wrra_pkg::weight_vec_t                 iport_weight_i,
    input  wire wrra_pkg::flit_vec_t                   flit_i,
    output wrra_pkg::port_mask_t [`WRRA_PORTS-1:0]      grant_o,         // [output][input]
    output wrra_pkg::port_mask_t                       out_valid_o,
    output wrra_pkg::flit_vec_t                        flit_o,
    output wrra_pkg::weight_vec_t                      contention_o
);
    import wrra_pkg::*;

    port_mask_t [`WRRA_PORTS-1:0] out_req;   // per output, requesting inputs

    always_comb begin
        for (int j = 0; j < `WRRA_PORTS; j++) begin
            for (int i = 0; i < `WRRA_PORTS; i++) begin
                out_req[j][i] = req_i[i] & dest_i[i][j];
            end
        end
    end

    contention_gen u_cont (
        .req_i          (req_i),
        .dest_i         (dest_i),
        .iport_weight_i (iport_weight_i),
        .contention_o   (contention_o)
    );

    for (genvar j = 0; j < `WRRA_PORTS; j++) begin : g_out
        wrra_arbiter u_arb (
            .clk         (clk),
            .reset       (reset),
            .request_i   (out_req[j]),
            .weight_i    (iport_weight_i),
            .grant_o     (grant_o[j]),
            .any_grant_o (out_valid_o[j])
        );

        header_weight_stamp u_stamp (
            .grant_i      (grant_o[j]),
            .flit_i       (flit_i),
            .contention_i (contention_o[j]),
            .flit_o       (flit_o[j])
        );
    end

endmodule

`default_nettype wire

// ==== wrra_qos.f ====
+incdir+verilog
verilog/wrra_pkg.sv
verilog/weight_counter.sv
verilog/rr_priority_arbiter.sv
verilog/wrra_arbiter.sv
verilog/contention_gen.sv
verilog/header_weight_stamp.sv
verilog/wrra_qos.sv
test/wrra_qos_props.sv
test/wrra_qos_tb.sv
